// ==== src.f ====
hw/dcache_pkg.sv
hw/dual_port_ram.sv
hw/line_ram.sv
hw/dcache.sv
hw/word_memory.sv
hw/dcache_subsystem.sv
test/dcache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --assert -Wno-fatal -f src.f --top-module dcache_tb -o dcache_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/dcache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# The log decides the result
if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0

// ==== test/dcache_tb.sv ====
// Data cache testbench
// Directed and random traffic against a shadow memory

`timescale 1ns/1ps

module dcache_tb
    import dcache_pkg::*;
();

    logic     clk;
    logic     reset;
    logic     enabled;
    addr_t    c_addr;
    data_t    c_data_out;
    logic     c_access;
    logic     c_wr_en;
    bytesel_t c_bytesel;
    data_t    c_data_in;
    logic     c_ack;

    // Expected memory contents, one entry per word address
    data_t shadow [2**$bits(addr_t)];

    int errors = 0;
    int test_start_errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int timeout_cycles = 200;
    logic [31:0] rng = 32'd21219;
    logic prev_access = 1'b0;

    dcache_subsystem UUT (
        .clk(clk),
        .reset(reset),
        .enabled(enabled),
        .c_addr(c_addr),
        .c_data_out(c_data_out),
        .c_access(c_access),
        .c_wr_en(c_wr_en),
        .c_bytesel(c_bytesel),
        .c_data_in(c_data_in),
        .c_ack(c_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Checks on every cycle, sampled mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            assert (!UUT.m_access && !UUT.m_wr_en)
                else begin
                    $display("memory request active during reset");
                    errors = errors + 1;
                end
        end
        // Ack may outlive the request by the one cycle it takes to fall
        assert (!c_ack || c_access || prev_access)
            else begin
                $display("c_ack high without a CPU request");
                errors = errors + 1;
            end
        prev_access <= c_access;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Word address is tag, then index, then offset
    function automatic addr_t make_addr(input tag_t tag, input index_t idx, input offset_t off);
        return {tag, idx, off};
    endfunction

    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input bytesel_t sel);
        data_t result;
        result = old_word;
        if (sel[0])
            result[7:0] = new_word[7:0];
        if (sel[1])
            result[15:8] = new_word[15:8];
        return result;
    endfunction

    // Called 5 ns after a rising edge, returns at the same point of a later cycle
    task automatic cpu_access(input logic wr, input addr_t addr, input data_t wdata,
                              input bytesel_t sel, output data_t rdata, output int cycles);
        int n;
        logic got_ack;
        c_addr = addr;
        c_data_out = wdata;
        c_wr_en = wr;
        c_bytesel = sel;
        c_access = 1'b1;
        n = 0;
        got_ack = 1'b0;
        while (!got_ack && n < timeout_cycles) begin
            @(posedge clk);
            #5;
            n = n + 1;
            got_ack = c_ack;
        end
        rdata = c_data_in;
        cycles = n;
        if (!got_ack) begin
            $display("timeout, no c_ack within %0d cycles for address %h", timeout_cycles, addr);
            errors = errors + 1;
        end
        c_access = 1'b0;
        c_wr_en = 1'b0;
        @(posedge clk);
        #5;
    endtask

    task automatic write_word(input addr_t addr, input data_t wdata, input bytesel_t sel,
                              output int cycles);
        data_t unused;
        cpu_access(1'b1, addr, wdata, sel, unused, cycles);
        shadow[addr] = merge_bytes(shadow[addr], wdata, sel);
    endtask

    task automatic read_check(input addr_t addr, output int cycles);
        data_t rdata;
        cpu_access(1'b0, addr, 16'h0000, 2'b11, rdata, cycles);
        assert (rdata == shadow[addr])
            else begin
                $display("ERR c_data_in at %h: got %h, expected %h", addr, rdata, shadow[addr]);
                errors = errors + 1;
            end
    endtask

    task automatic check_latency(input int cycles, input int expected);
        assert (cycles == expected)
            else begin
                $display("ERR c_ack latency: got %h cycles, expected %h", cycles, expected);
                errors = errors + 1;
            end
    endtask

    task automatic finish_test(input string name);
        int found;
        found = errors - test_start_errors;
        if (found == 0) begin
            $display("test %s: ok", name);
            tests_passed = tests_passed + 1;
        end else begin
            $display("test %s: %0d errors", name, found);
            tests_failed = tests_failed + 1;
        end
        test_start_errors = errors;
    endtask

    initial begin
        addr_t bases [3];
        addr_t addr;
        int cycles;
        int clean_cycles;
        int dirty_cycles;
        tag_t tag;
        index_t idx;
        bytesel_t sel;

        reset = 1'b1;
        // Cache on through reset, the memory side then comes from the controller
        enabled = 1'b1;
        c_addr = '0;
        c_data_out = '0;
        c_access = 1'b0;
        c_wr_en = 1'b0;
        c_bytesel = 2'b11;
        repeat (3) @(posedge clk);
        #5;
        reset = 1'b0;

        // Idle with the cache on, nothing may move
        repeat (6) begin
            @(posedge clk);
            #5;
            assert (!c_ack && !UUT.m_access)
                else begin
                    $display("ack or memory request with no access pending");
                    errors = errors + 1;
                end
        end
        finish_test("idle after reset");

        // Lines a and b share index 0x10, line c sits next to them
        bases[0] = make_addr(7'd1, 9'h010, 3'd0);
        bases[1] = make_addr(7'd2, 9'h010, 3'd0);
        bases[2] = make_addr(7'd1, 9'h011, 3'd0);
        enabled = 1'b0;
        for (int l = 0; l < 3; l++) begin
            for (int w = 0; w < line_words; w++) begin
                addr = bases[l] + addr_t'(w);
                write_word(addr, addr[15:0] ^ 16'ha5c3, 2'b11, cycles);
            end
        end
        for (int l = 0; l < 3; l++) begin
            for (int w = 0; w < line_words; w++)
                read_check(bases[l] + addr_t'(w), cycles);
        end
        finish_test("bypass write and read");

        // First read fills line a, the neighbour word then hits
        enabled = 1'b1;
        read_check(bases[0] + 19'd3, clean_cycles);
        read_check(bases[0] + 19'd4, cycles);
        check_latency(cycles, 2);
        finish_test("miss then hit");

        // Each byte lane alone, then both
        for (int s = 1; s < 4; s++) begin
            rng = xorshift32(rng);
            write_word(bases[0] + 19'd4, rng[15:0], bytesel_t'(s), cycles);
            check_latency(cycles, 2);
            read_check(bases[0] + 19'd4, cycles);
        end
        finish_test("byte write hit");

        // Line a is dirty, reading line b forces the write-back
        rng = xorshift32(rng);
        write_word(bases[0] + 19'd5, rng[15:0], 2'b11, cycles);
        read_check(bases[1] + 19'd2, dirty_cycles);
        assert (dirty_cycles > clean_cycles)
            else begin
                $display("dirty miss was not slower than a clean miss");
                errors = errors + 1;
            end
        enabled = 1'b0;
        read_check(bases[0] + 19'd5, cycles);
        read_check(bases[0] + 19'd4, cycles);
        read_check(bases[0] + 19'd3, cycles);
        finish_test("dirty eviction");

        // Four tags on two indexes, preloaded straight into memory
        for (int t = 1; t < 5; t++) begin
            for (int i = 0; i < 2; i++) begin
                for (int w = 0; w < line_words; w++) begin
                    rng = xorshift32(rng);
                    addr = make_addr(tag_t'(t), 9'h020 + index_t'(i), offset_t'(w));
                    write_word(addr, rng[15:0], 2'b11, cycles);
                end
            end
        end
        enabled = 1'b1;
        for (int k = 0; k < 300; k++) begin
            rng = xorshift32(rng);
            tag = tag_t'(rng[1:0]) + 7'd1;
            idx = rng[2] ? 9'h021 : 9'h020;
            addr = make_addr(tag, idx, rng[5:3]);
            sel = (rng[8:7] == 2'b00) ? 2'b11 : rng[8:7];
            if (rng[6])
                write_word(addr, rng[31:16], sel, cycles);
            else
                read_check(addr, cycles);
        end
        finish_test("random traffic");

        $display("tests: %0d ok, %0d with errors, %0d check errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== hw/dcache_subsystem.sv ====
// Data cache subsystem top
// Cache in front of the word memory

`timescale 1ns/1ps

module dcache_subsystem
    import dcache_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     enabled,
    // CPU side
    input  addr_t    c_addr,
    input  data_t    c_data_out,
    input  logic     c_access,
    input  logic     c_wr_en,
    input  bytesel_t c_bytesel,
    output data_t    c_data_in,
    output logic     c_ack
);

    // Memory side wires
    addr_t    m_addr;
    data_t    m_data_out;
    data_t    m_data_in;
    logic     m_access;
    logic     m_wr_en;
    logic     m_ack;
    bytesel_t m_bytesel;

    dcache cache (
        .clk(clk),
        .reset(reset),
        .enabled(enabled),
        .c_addr(c_addr),
        .c_data_out(c_data_out),
        .c_access(c_access),
        .c_wr_en(c_wr_en),
        .c_bytesel(c_bytesel),
        .c_data_in(c_data_in),
        .c_ack(c_ack),
        .m_data_in(m_data_in),
        .m_ack(m_ack),
        .m_addr(m_addr),
        .m_data_out(m_data_out),
        .m_access(m_access),
        .m_wr_en(m_wr_en),
        .m_bytesel(m_bytesel)
    );

    word_memory memory (
        .clk(clk),
        .reset(reset),
        .m_addr(m_addr),
        .m_data_out(m_data_out),
        .m_access(m_access),
        .m_wr_en(m_wr_en),
        .m_bytesel(m_bytesel),
        .m_data_in(m_data_in),
        .m_ack(m_ack)
    );

endmodule

// ==== hw/word_memory.sv ====
// Backing word memory
// Fixed latency, single-cycle ack

`timescale 1ns/1ps

module word_memory
    import dcache_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  addr_t    m_addr,
    input  data_t    m_data_out,
    input  logic     m_access,
    input  logic     m_wr_en,
    input  bytesel_t m_bytesel,
    output data_t    m_data_in,
    output logic     m_ack
);

    // Full word address space
    data_t mem [2**$bits(addr_t)];

    // Cycles the current request has been held
    logic [$clog2(mem_latency+1)-1:0] count;
    logic ack_now;

    // Request held long enough, ack on this edge
    assign ack_now = m_access && !m_ack && (count == mem_latency - 1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            m_ack <= 1'b0;
            count <= '0;
        end else if (m_ack) begin
            // Ack cycle ends the request, the next one counts afresh
            m_ack <= 1'b0;
            count <= '0;
        end else if (ack_now) begin
            m_ack <= 1'b1;
            count <= '0;
        end else if (m_access) begin
            count <= count + 1'b1;
        end else begin
            count <= '0;
        end
    end

    // Array access on the edge that raises the ack
    always_ff @(posedge clk) begin
        if (ack_now) begin
            if (m_wr_en) begin
                if (m_bytesel[0])
                    mem[m_addr][7:0] <= m_data_out[7:0];
                if (m_bytesel[1])
                    mem[m_addr][15:8] <= m_data_out[15:8];
            end
            m_data_in <= mem[m_addr];
        end
    end

endmodule

// ==== hw/dcache.sv ====
// Direct-mapped write-back data cache
// Lookup, flush and fill bursts, bypass path

`timescale 1ns/1ps

module dcache
    import dcache_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     enabled,
    // CPU side
    input  addr_t    c_addr,
    input  data_t    c_data_out,
    input  logic     c_access,
    input  logic     c_wr_en,
    input  bytesel_t c_bytesel,
    output data_t    c_data_in,
    output logic     c_ack,
    // Memory side
    input  data_t    m_data_in,
    input  logic     m_ack,
    output addr_t    m_addr,
    output data_t    m_data_out,
    output logic     m_access,
    output logic     m_wr_en,
    output bytesel_t m_bytesel
);

    cache_state_t state;
    logic c_ack_reg;

    // Burst position, wraps back to zero after each burst
    offset_t burst_offset;
    offset_t b_offset;

    // Words of the last filled line that have arrived
    logic [line_words-1:0] filled;
    logic [tag_bits+index_bits-1:0] fill_line;

    // Request address held across the miss handling
    addr_t latched_addr;
    addr_t m_addr_reg;

    // CPU address fields, drive the lookup read ports
    index_t c_index;
    offset_t c_offset;

    // Latched address fields
    tag_t l_tag;
    index_t l_index;
    offset_t l_offset;

    // Array outputs
    tag_t tag_q;
    logic valid_q;
    logic dirty_q;
    data_t c_q;
    data_t line_q;

    logic tag_hit;
    logic fill_hit;
    logic hit;
    logic write_hit;
    logic last_ack;
    logic victim_dirty;
    logic fill_done;
    logic burst_done;

    assign c_index = c_addr[offset_bits +: index_bits];
    assign c_offset = c_addr[offset_bits-1:0];
    assign l_tag = latched_addr[offset_bits+index_bits +: tag_bits];
    assign l_index = latched_addr[offset_bits +: index_bits];
    assign l_offset = latched_addr[offset_bits-1:0];

    // Hit on the stored tag, or on a word already brought in by the last fill
    // The second term covers the cycle where the new tag is not yet readable
    assign tag_hit = valid_q && (tag_q == l_tag);
    assign fill_hit = filled[l_offset] && (fill_line == {l_tag, l_index});
    assign hit = tag_hit || fill_hit;
    assign write_hit = enabled && (state == lookup) && hit && c_wr_en;

    // Only a valid dirty line needs writing back
    assign victim_dirty = valid_q && dirty_q;

    assign last_ack = m_ack && (burst_offset == offset_t'(line_words - 1));
    assign fill_done = (state == fill) && last_ack;
    assign burst_done = ((state == flush) || (state == fill)) && last_ack;

    // Flush reads one word ahead so the next word is ready after each ack
    assign b_offset = ((state == flush) && m_ack) ? burst_offset + 1'b1 : burst_offset;

    // Bypass passes the CPU straight through to memory
    assign c_ack = enabled ? c_ack_reg : m_ack;
    assign c_data_in = enabled ? c_q : m_data_in;
    assign m_addr = enabled ? m_addr_reg : c_addr;
    assign m_data_out = enabled ? line_q : c_data_out;
    assign m_bytesel = enabled ? 2'b11 : c_bytesel;
    // Request drops in the ack cycle
    assign m_access = enabled ? (((state == flush) || (state == fill)) && !m_ack) : c_access;
    assign m_wr_en = enabled ? ((state == flush) && !m_ack) : c_wr_en;

    // Tag array, written at the end of a fill
    dual_port_ram #(.depth(dcache_lines), .width(tag_bits)) tag_ram (
        .clk(clk),
        .addr_a(c_index),
        .wdata_a('0),
        .wr_en_a(1'b0),
        .q_a(tag_q),
        .addr_b(l_index),
        .wdata_b(l_tag),
        .wr_en_b(fill_done),
        .q_b()
    );

    // Valid array
    dual_port_ram #(.depth(dcache_lines), .width(1)) valid_ram (
        .clk(clk),
        .addr_a(c_index),
        .wdata_a(1'b0),
        .wr_en_a(1'b0),
        .q_a(valid_q),
        .addr_b(l_index),
        .wdata_b(1'b1),
        .wr_en_b(fill_done),
        .q_b()
    );

    // Dirty array, set by write hits, cleared when a burst completes
    dual_port_ram #(.depth(dcache_lines), .width(1)) dirty_ram (
        .clk(clk),
        .addr_a(c_index),
        .wdata_a(1'b1),
        .wr_en_a(write_hit),
        .q_a(dirty_q),
        .addr_b(l_index),
        .wdata_b(1'b0),
        .wr_en_b(burst_done),
        .q_b()
    );

    // Line data, port a for the CPU, port b for bursts
    line_ram data_ram (
        .clk(clk),
        .addr_a({c_index, c_offset}),
        .wdata_a(c_data_out),
        .be_a(c_bytesel),
        .wr_en_a(write_hit),
        .q_a(c_q),
        .addr_b({l_index, b_offset}),
        .wdata_b(m_data_in),
        .be_b(2'b11),
        .wr_en_b((state == fill) && m_ack),
        .q_b(line_q)
    );

    // Controller FSM and CPU ack
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= idle;
            c_ack_reg <= 1'b0;
            burst_offset <= '0;
            filled <= '0;
        end else begin
            // Ack holds until the CPU drops its request
            if (!c_access)
                c_ack_reg <= 1'b0;
            else if ((state == lookup) && hit)
                c_ack_reg <= 1'b1;

            case (state)
                idle: begin
                    // A held request that was already acked does not restart
                    if (enabled && c_access && !c_ack_reg)
                        state <= lookup;
                end
                lookup: begin
                    if (hit) begin
                        state <= idle;
                    end else begin
                        filled <= '0;
                        state <= victim_dirty ? flush : fill;
                    end
                end
                flush: begin
                    if (m_ack) begin
                        burst_offset <= burst_offset + 1'b1;
                        if (last_ack)
                            state <= fill;
                    end
                end
                fill: begin
                    if (m_ack) begin
                        filled[burst_offset] <= 1'b1;
                        burst_offset <= burst_offset + 1'b1;
                        // Look up again, the mask covers the stale tag read
                        if (last_ack)
                            state <= lookup;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Request address and burst address
    always_ff @(posedge clk) begin
        if (state == idle)
            latched_addr <= c_addr;

        if ((state == lookup) && !hit) begin
            fill_line <= {l_tag, l_index};
            // Write back from the victim tag, otherwise fetch the new line
            if (victim_dirty)
                m_addr_reg <= {tag_q, l_index, offset_t'(0)};
            else
                m_addr_reg <= {l_tag, l_index, offset_t'(0)};
        end else if (((state == flush) || (state == fill)) && m_ack) begin
            if ((state == flush) && last_ack)
                m_addr_reg <= {l_tag, l_index, offset_t'(0)};
            else
                m_addr_reg <= {m_addr_reg[$bits(addr_t)-1:offset_bits],
                               m_addr_reg[offset_bits-1:0] + 1'b1};
        end
    end

endmodule

// ==== hw/line_ram.sv ====
// Cache line data RAM
// Two ports with byte enables

`timescale 1ns/1ps

module line_ram
    import dcache_pkg::*;
(
    input  logic                              clk,
    // Port a, CPU side
    input  logic [index_bits+offset_bits-1:0] addr_a,
    input  data_t                             wdata_a,
    input  bytesel_t                          be_a,
    input  logic                              wr_en_a,
    output data_t                             q_a,
    // Port b, burst side
    input  logic [index_bits+offset_bits-1:0] addr_b,
    input  data_t                             wdata_b,
    input  bytesel_t                          be_b,
    input  logic                              wr_en_b,
    output data_t                             q_b
);

    // One entry per word, address is index then offset
    data_t mem [dcache_lines*line_words];

    always_ff @(posedge clk) begin
        // Byte-masked writes on both ports
        if (wr_en_a) begin
            if (be_a[0])
                mem[addr_a][7:0] <= wdata_a[7:0];
            if (be_a[1])
                mem[addr_a][15:8] <= wdata_a[15:8];
        end
        if (wr_en_b) begin
            if (be_b[0])
                mem[addr_b][7:0] <= wdata_b[7:0];
            if (be_b[1])
                mem[addr_b][15:8] <= wdata_b[15:8];
        end
        // Reads see the old word on a same-edge write
        q_a <= mem[addr_a];
        q_b <= mem[addr_b];
    end

endmodule

// ==== hw/dual_port_ram.sv ====
// Two-port synchronous RAM

`timescale 1ns/1ps

module dual_port_ram #(
    parameter int depth = 512,
    parameter int width = 8
) (
    input  logic                     clk,
    // Port a
    input  logic [$clog2(depth)-1:0] addr_a,
    input  logic [width-1:0]         wdata_a,
    input  logic                     wr_en_a,
    output logic [width-1:0]         q_a,
    // Port b
    input  logic [$clog2(depth)-1:0] addr_b,
    input  logic [width-1:0]         wdata_b,
    input  logic                     wr_en_b,
    output logic [width-1:0]         q_b
);

    logic [width-1:0] mem [depth];

    // Registered reads return the contents before a same-edge write
    always_ff @(posedge clk) begin
        if (wr_en_a)
            mem[addr_a] <= wdata_a;
        if (wr_en_b)
            mem[addr_b] <= wdata_b;
        q_a <= mem[addr_a];
        q_b <= mem[addr_b];
    end

endmodule

// ==== hw/dcache_pkg.sv ====
// Data cache shared definitions
// Geometry, widths and controller states

package dcache_pkg;

    // Cache geometry
    localparam int dcache_lines = 512;
    localparam int line_words = 8;

    // Address split, tag above index above word offset
    localparam int offset_bits = 3;
    localparam int index_bits = 9;
    localparam int tag_bits = 7;

    // Cycles from request to ack in the backing memory
    localparam int mem_latency = 2;

    // CPU word address
    typedef logic [18:0] addr_t;

    // One memory word
    typedef logic [15:0] data_t;

    // Byte lane selects, bit 0 is the low byte
    typedef logic [1:0] bytesel_t;

    // Fields of a word address
    typedef logic [index_bits-1:0] index_t;
    typedef logic [tag_bits-1:0] tag_t;
    typedef logic [offset_bits-1:0] offset_t;

    // Controller states
    typedef enum logic [1:0] {
        idle,
        lookup,
        flush,
        fill
    } cache_state_t;

endpackage
